//--- rtl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

  // Key code, one-hot row in the upper nibble, one-hot column in the lower
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [3:0] row; // Bit 7 is row 0
      logic [3:0] col; // Bit 3 is column 0
    } fields;
  } key_code_u;

  // Multi-tap position, S0 to S3 pick the letter within a key
  typedef enum logic [2:0] {
    INIT = 3'd0,
    S0   = 3'd1,
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4,
    DONE = 3'd5
  } tap_state_e;

  // Letter keys
  localparam logic [7:0] KEY_2 = 8'b1000_0100; // R0 C1
  localparam logic [7:0] KEY_3 = 8'b1000_0010; // R0 C2
  localparam logic [7:0] KEY_4 = 8'b0100_1000; // R1 C0
  localparam logic [7:0] KEY_5 = 8'b0100_0100; // R1 C1
  localparam logic [7:0] KEY_6 = 8'b0100_0010; // R1 C2
  localparam logic [7:0] KEY_7 = 8'b0010_1000; // R2 C0, four letters
  localparam logic [7:0] KEY_8 = 8'b0010_0100; // R2 C1
  localparam logic [7:0] KEY_9 = 8'b0010_0010; // R2 C2, four letters

  // Control keys
  localparam logic [7:0] KEY_SUBMIT_LETTER = 8'b0001_1000; // R3 C0
  localparam logic [7:0] KEY_CLEAR         = 8'b0001_0100; // R3 C1
  localparam logic [7:0] KEY_SUBMIT_WORD   = 8'b0001_0010; // R3 C2
  localparam logic [7:0] KEY_GAME_END      = 8'b0010_0001; // R2 C3

  // Keys with no function
  localparam logic [7:0] KEY_1 = 8'b1000_1000; // R0 C0
  localparam logic [7:0] KEY_A = 8'b1000_0001; // R0 C3
  localparam logic [7:0] KEY_B = 8'b0100_0001; // R1 C3
  localparam logic [7:0] KEY_D = 8'b0001_0001; // R3 C3

  // First ASCII letter on each key
  localparam logic [7:0] BASE_2 = 8'h41; // A
  localparam logic [7:0] BASE_3 = 8'h44; // D
  localparam logic [7:0] BASE_4 = 8'h47; // G
  localparam logic [7:0] BASE_5 = 8'h4A; // J
  localparam logic [7:0] BASE_6 = 8'h4D; // M
  localparam logic [7:0] BASE_7 = 8'h50; // P
  localparam logic [7:0] BASE_8 = 8'h54; // T
  localparam logic [7:0] BASE_9 = 8'h57; // W

  localparam int SCAN_DWELL     = 4; // Cycles per column
  localparam int DEBOUNCE_SCANS = 3; // Matching scans before accept
  localparam int WORD_LEN       = 5;

  // Counter widths
  localparam int SCAN_CNT_W = $clog2(SCAN_DWELL);
  localparam int DEB_CNT_W  = $clog2(DEBOUNCE_SCANS + 1);
  localparam int WORD_CNT_W = $clog2(WORD_LEN + 1);

endpackage

`default_nettype wire

//--- rtl/letter_if.sv
`timescale 1ns/1ps
`default_nettype none

// Letter events from the keypad FSM to the word assembler
interface letter_if;
  logic       ready;        // One-cycle pulse, letter submitted
  logic [7:0] data;         // ASCII letter in progress or submitted
  logic       toggle_state; // Word submit pulse
  logic       game_end;     // Game end pulse

  modport source (
    output ready,
    output data,
    output toggle_state,
    output game_end
  );

  modport sink (
    input ready,
    input data,
    input toggle_state,
    input game_end
  );
endinterface

`default_nettype wire

//--- rtl/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4 matrix scanner
// cols[3] drives column 0 and rows[3] reads row 0, matching the key code bits
module keypad_scanner (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic [3:0]            rows,
  output logic [3:0]            cols,
  output keypad_pkg::key_code_u cur_key,
  output logic                  strobe
);
  import keypad_pkg::*;

  logic [SCAN_CNT_W-1:0] dwell_cnt;   // Cycles spent on current column
  logic                  dwell_end;
  logic                  scan_end;    // Last column sampled
  key_code_u             col_hit;     // Key found in the driven column
  key_code_u             scan_acc;    // First key of the scan so far
  key_code_u             scan_result;
  key_code_u             cand;        // Result being confirmed
  logic [DEB_CNT_W-1:0]  match_cnt;
  logic [DEB_CNT_W-1:0]  next_cnt;

  // Lowest numbered row wins when several are active
  function automatic logic [3:0] first_row(input logic [3:0] r);
    if (r[3])
      first_row = 4'b1000;
    else if (r[2])
      first_row = 4'b0100;
    else if (r[1])
      first_row = 4'b0010;
    else if (r[0])
      first_row = 4'b0001;
    else
      first_row = 4'b0000;
  endfunction

  assign dwell_end = (dwell_cnt == SCAN_CNT_W'(SCAN_DWELL - 1));
  assign scan_end  = dwell_end && cols[0];

  always_comb begin
    col_hit.fields.row = first_row(rows);
    col_hit.fields.col = (|rows) ? cols : 4'b0000; // Zero code if column idle
  end

  // Earlier columns take priority
  assign scan_result = (|scan_acc.raw) ? scan_acc : col_hit;

  always_comb begin
    if (scan_result.raw != cand.raw)
      next_cnt = DEB_CNT_W'(1); // New candidate, first sighting
    else if (match_cnt == DEB_CNT_W'(DEBOUNCE_SCANS))
      next_cnt = match_cnt;     // Saturate
    else
      next_cnt = match_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      dwell_cnt <= '0;
      cols      <= 4'b1000; // Column 0
      scan_acc  <= '0;
      cand      <= '0;
      match_cnt <= '0;
      cur_key   <= '0;
      strobe    <= 1'b0;
    end else begin
      strobe <= 1'b0;
      if (dwell_end) begin
        dwell_cnt <= '0;
        cols      <= {cols[0], cols[3:1]}; // Next column, wraps to column 0
        if (scan_end) begin
          scan_acc  <= '0;
          cand      <= scan_result;
          match_cnt <= next_cnt;
          // Stable long enough and different from what is reported
          if (next_cnt == DEB_CNT_W'(DEBOUNCE_SCANS) &&
              scan_result.raw != cur_key.raw) begin
            cur_key <= scan_result;
            strobe  <= (cur_key.raw == 8'd0); // Press edge only
          end
        end else if (scan_acc.raw == 8'd0) begin
          scan_acc <= col_hit; // Keep first hit of this scan
        end
      end else begin
        dwell_cnt <= dwell_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/keypad_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// Multi-tap letter entry, phone style
module keypad_fsm (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::key_code_u cur_key,
  input  logic                  strobe,
  letter_if.source              letters
);
  import keypad_pkg::*;

  tap_state_e state;
  tap_state_e next_state;
  tap_state_e tap_next;   // Tap position after a letter press
  key_code_u  prev_key;   // Last valid key, taken in strobe cycle
  key_code_u  next_prev;
  logic [7:0] next_data;
  logic [7:0] base;       // First letter of current key
  logic       is_invalid;
  logic       is_four;    // Keys 7 and 9

  // Zero for anything that is not a letter key
  function automatic logic [7:0] letter_base(input key_code_u k);
    case (k.raw)
      KEY_2:   letter_base = BASE_2;
      KEY_3:   letter_base = BASE_3;
      KEY_4:   letter_base = BASE_4;
      KEY_5:   letter_base = BASE_5;
      KEY_6:   letter_base = BASE_6;
      KEY_7:   letter_base = BASE_7;
      KEY_8:   letter_base = BASE_8;
      KEY_9:   letter_base = BASE_9;
      default: letter_base = 8'd0;
    endcase
  endfunction

  // Offset from the base letter
  function automatic logic [7:0] tap_index(input tap_state_e s);
    case (s)
      S1:      tap_index = 8'd1;
      S2:      tap_index = 8'd2;
      S3:      tap_index = 8'd3;
      default: tap_index = 8'd0;
    endcase
  endfunction

  // Same key pressed again
  function automatic tap_state_e advance(input tap_state_e s, input logic four);
    case (s)
      INIT:    advance = S0;
      S0:      advance = S1;
      S1:      advance = S2;
      S2:      advance = four ? S3 : S0; // Wrap after third letter on 3-letter keys
      default: advance = S0;             // S3 wraps too
    endcase
  endfunction

  assign base       = letter_base(cur_key);
  assign is_four    = (cur_key.raw == KEY_7) || (cur_key.raw == KEY_9);
  assign is_invalid = cur_key.raw inside {KEY_1, KEY_A, KEY_B, KEY_D};

  always_comb begin
    next_state           = state;
    next_data            = letters.data;
    next_prev            = prev_key;
    tap_next             = S0;
    letters.toggle_state = 1'b0;
    letters.game_end     = 1'b0;

    if (state == DONE)
      next_state = INIT; // Letter handed over, start fresh

    if (strobe && !is_invalid) begin
      next_prev = cur_key;
      case (cur_key.raw)
        KEY_SUBMIT_LETTER: begin
          // Only with a letter pending
          if (state inside {S0, S1, S2, S3})
            next_state = DONE;
        end
        KEY_CLEAR: begin
          next_state = INIT;
          next_data  = 8'd0;
        end
        KEY_GAME_END: begin
          next_state       = INIT;
          next_data        = 8'd0;
          letters.game_end = 1'b1;
        end
        KEY_SUBMIT_WORD: begin
          next_state           = INIT;
          next_data            = 8'd0;
          letters.toggle_state = 1'b1;
        end
        default: begin
          // Letter keys 2 to 9, never taken while DONE
          if (state != DONE) begin
            if (cur_key.raw == prev_key.raw)
              tap_next = advance(state, is_four);
            else
              tap_next = S0; // New key restarts the count
            next_state = tap_next;
            next_data  = base + tap_index(tap_next);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state         <= INIT;
      prev_key      <= '0;
      letters.data  <= 8'd0;
      letters.ready <= 1'b0;
    end else begin
      state         <= next_state;
      prev_key      <= next_prev;
      letters.data  <= next_data;
      letters.ready <= (state == DONE); // Cycle after DONE
    end
  end

endmodule

`default_nettype wire

//--- rtl/word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

// Collects submitted letters into a fixed-length word
module word_assembler (
  input  logic                                 clk,
  input  logic                                 nRst,
  letter_if.sink                               letters,
  output logic [keypad_pkg::WORD_LEN-1:0][7:0] word,
  output logic                                 word_valid,
  output logic                                 game_over
);
  import keypad_pkg::*;

  logic [WORD_LEN-1:0][7:0] letter_buf; // Newest letter in byte 0
  logic [WORD_CNT_W-1:0]    count;      // Letters held
  logic                     buf_full;

  assign buf_full = (count == WORD_CNT_W'(WORD_LEN));

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      letter_buf <= '0;
      count      <= '0;
      word       <= '0;
      word_valid <= 1'b0;
      game_over  <= 1'b0;
    end else begin
      word_valid <= 1'b0;

      if (letters.game_end)
        game_over <= 1'b1; // Sticky until reset

      if (!game_over) begin
        if (letters.toggle_state) begin
          // Only a complete word is reported
          if (buf_full) begin
            word       <= letter_buf; // First letter lands in MSB byte
            word_valid <= 1'b1;
          end
          letter_buf <= '0;
          count      <= '0;
        end else if (letters.ready && !buf_full) begin
          letter_buf <= {letter_buf[WORD_LEN-2:0], letters.data};
          count      <= count + 1'b1;
        end
        // Letters past WORD_LEN are dropped
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/keypad_entry_top.sv
`timescale 1ns/1ps
`default_nettype none

// Keypad letter entry, scanner to multi-tap FSM to word assembler
module keypad_entry_top (
  input  logic                                 clk,
  input  logic                                 nRst,
  input  logic [3:0]                           rows,         // rows[3] is row 0
  output logic [3:0]                           cols,         // cols[3] is column 0
  output logic                                 letter_ready,
  output logic [7:0]                           letter,
  output logic                                 word_valid,
  output logic [keypad_pkg::WORD_LEN-1:0][7:0] word,
  output logic                                 game_over
);
  import keypad_pkg::*;

  key_code_u cur_key; // Debounced key
  logic      strobe;  // New press

  letter_if letters_if ();

  keypad_scanner u_scanner (
    .clk     (clk),
    .nRst    (nRst),
    .rows    (rows),
    .cols    (cols),
    .cur_key (cur_key),
    .strobe  (strobe)
  );

  keypad_fsm u_fsm (
    .clk     (clk),
    .nRst    (nRst),
    .cur_key (cur_key),
    .strobe  (strobe),
    .letters (letters_if.source)
  );

  word_assembler u_assembler (
    .clk        (clk),
    .nRst       (nRst),
    .letters    (letters_if.sink),
    .word       (word),
    .word_valid (word_valid),
    .game_over  (game_over)
  );

  // Letter events also visible outside
  assign letter_ready = letters_if.ready;
  assign letter       = letters_if.data;

endmodule

`default_nettype wire

//--- bench/keypad_entry_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the multi-tap FSM
module keypad_entry_properties (
  input logic                   clk,
  input logic                   nRst,
  input keypad_pkg::tap_state_e state,
  input logic                   strobe,
  input logic                   ready,
  input logic                   toggle_state,
  input logic                   game_end
);
  import keypad_pkg::*;

  // Letter handover is a single pulse
  ready_single_pulse: assert property (@(posedge clk) disable iff (!nRst)
    ready |=> !ready)
    else $error("letter ready high in two consecutive cycles");

  done_returns_to_init: assert property (@(posedge clk) disable iff (!nRst)
    (state == DONE) |=> (state == INIT))
    else $error("FSM left DONE for a state other than INIT");

  toggle_needs_strobe: assert property (@(posedge clk) disable iff (!nRst)
    $rose(toggle_state) |-> strobe)
    else $error("word submit pulse without a key strobe");

  game_end_needs_strobe: assert property (@(posedge clk) disable iff (!nRst)
    $rose(game_end) |-> strobe)
    else $error("game end pulse without a key strobe");

endmodule

bind keypad_fsm keypad_entry_properties u_properties (
  .clk          (clk),
  .nRst         (nRst),
  .state        (state),
  .strobe       (strobe),
  .ready        (letters.ready),
  .toggle_state (letters.toggle_state),
  .game_end     (letters.game_end)
);

`default_nettype wire

//--- bench/keypad_entry_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Drives the keypad matrix with random presses, checks letters, words and game over
module keypad_entry_tb;
  import keypad_pkg::*;

  localparam int TIMEOUT = 1000; // Cycles allowed per wait

  typedef logic [WORD_LEN-1:0][7:0] word_t;

  logic       clk = 1'b0;
  logic       nRst;
  logic [3:0] rows;
  logic [3:0] cols;
  logic       letter_ready;
  logic [7:0] letter;
  logic       word_valid;
  word_t      word;
  logic       game_over;

  key_code_u  held;            // Key down on the matrix, zero when none
  integer     seed = 93;
  int         errors = 0;
  int         checks = 0;
  int         cyc = 0;         // Negedge count
  int         last_strobe = 0; // Cycle of the latest press strobe
  logic       timed_out = 1'b0;

  // Reference model
  logic [7:0] m_prev;          // Last key that was not invalid
  int         m_taps;          // Presses of m_prev in the current run, 0 if none pending
  logic [7:0] m_buf[$];        // Letters of the word so far
  logic       m_game_over;
  logic [7:0] exp_letters[$];
  logic [7:0] got_letters[$];
  word_t      exp_words[$];
  word_t      got_words[$];

  logic [7:0] letter_keys[8] = '{KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9};
  logic [7:0] bad_keys[4]    = '{KEY_1, KEY_A, KEY_B, KEY_D};

  keypad_entry_top DUT (
    .clk          (clk),
    .nRst         (nRst),
    .rows         (rows),
    .cols         (cols),
    .letter_ready (letter_ready),
    .letter       (letter),
    .word_valid   (word_valid),
    .word         (word),
    .game_over    (game_over)
  );

  always #5 clk = ~clk;

  // Matrix model, row of the held key shows only while its column is driven
  assign rows = (|(cols & held.fields.col)) ? held.fields.row : 4'b0000;

  // Event capture with latency checks
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (DUT.strobe)
      last_strobe = cyc;
    if (letter_ready) begin
      got_letters.push_back(letter);
      if (cyc - last_strobe != 2) begin
        $display("Letter ready at %0t came %0d cycles after the press instead of 2",
                 $time, cyc - last_strobe);
        errors++;
      end
    end
    if (word_valid) begin
      got_words.push_back(word);
      if (cyc - last_strobe != 1) begin
        $display("Word valid at %0t came %0d cycles after the press instead of 1",
                 $time, cyc - last_strobe);
        errors++;
      end
    end
  end

  task automatic check_letter(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Phone layout, first letter per key
  function automatic logic [7:0] key_base(input logic [7:0] key);
    case (key)
      KEY_2:   key_base = "A";
      KEY_3:   key_base = "D";
      KEY_4:   key_base = "G";
      KEY_5:   key_base = "J";
      KEY_6:   key_base = "M";
      KEY_7:   key_base = "P";
      KEY_8:   key_base = "T";
      KEY_9:   key_base = "W";
      default: key_base = 8'h00; // Not a letter key
    endcase
  endfunction

  function automatic int group_size(input logic [7:0] key);
    return (key == KEY_7 || key == KEY_9) ? 4 : 3;
  endfunction

  task automatic model_reset();
    m_prev      = 8'h00;
    m_taps      = 0;
    m_game_over = 1'b0;
    m_buf.delete();
    exp_letters.delete();
    got_letters.delete();
    exp_words.delete();
    got_words.delete();
  endtask

  // Expected effect of one accepted press
  task automatic model_press(input logic [7:0] key);
    logic [7:0] ltr;
    word_t      w;
    ltr = key_base(m_prev) + 8'((m_taps - 1) % group_size(m_prev));
    if (key == KEY_SUBMIT_LETTER && m_taps > 0) begin
      exp_letters.push_back(ltr); // FSM hands it over even after game end
      if (!m_game_over && m_buf.size() < WORD_LEN)
        m_buf.push_back(ltr);     // Sixth letter onward dropped
    end else if (key == KEY_SUBMIT_WORD && !m_game_over) begin
      if (m_buf.size() == WORD_LEN) begin
        for (int i = 0; i < WORD_LEN; i++)
          w[WORD_LEN-1-i] = m_buf[i]; // First letter in top byte
        exp_words.push_back(w);
      end
      m_buf.delete();
    end else if (key == KEY_GAME_END) begin
      m_game_over = 1'b1;
    end
    if (key_base(key) != 8'h00) begin
      m_taps = (key == m_prev) ? m_taps + 1 : 1;
      m_prev = key;
    end else if (!(key inside {KEY_1, KEY_A, KEY_B, KEY_D})) begin
      m_taps = 0; // Control keys end any run
      m_prev = key;
    end
  endtask

  task automatic compare_events();
    logic [7:0] g;
    logic [7:0] e;
    word_t      gw;
    word_t      ew;
    if (got_letters.size() != exp_letters.size()) begin
      $display("At %0t the DUT gave %0d letters where %0d were expected",
               $time, got_letters.size(), exp_letters.size());
      errors++;
    end
    while (got_letters.size() > 0 && exp_letters.size() > 0) begin
      g = got_letters.pop_front();
      e = exp_letters.pop_front();
      check_letter("letter", g, e);
    end
    if (got_words.size() != exp_words.size()) begin
      $display("At %0t the DUT gave %0d words where %0d were expected",
               $time, got_words.size(), exp_words.size());
      errors++;
    end
    while (got_words.size() > 0 && exp_words.size() > 0) begin
      gw = got_words.pop_front();
      ew = exp_words.pop_front();
      check_word("word", gw, ew);
    end
    got_letters.delete();
    exp_letters.delete();
    got_words.delete();
    exp_words.delete();
    check_flag("game_over", game_over, m_game_over);
  endtask

  // Press, hold past the strobe, release until the scanner sees it gone
  task automatic press_key(input logic [7:0] key);
    int n;
    int extra;
    if (timed_out)
      return;
    @(posedge clk);
    #1 held.raw = key;
    n = 0;
    @(negedge clk);
    while (!DUT.strobe && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!DUT.strobe) begin
      $display("Timeout: the scanner never reported key %h", key);
      errors++;
      timed_out = 1'b1;
      return;
    end
    model_press(key);
    extra = 1 + $unsigned($random(seed)) % 4;
    repeat (extra) @(posedge clk);
    #1 held = '0;
    n = 0;
    @(negedge clk);
    while (DUT.cur_key.raw != 8'h00 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (DUT.cur_key.raw != 8'h00) begin
      $display("Timeout: the scanner never saw key %h released", key);
      errors++;
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);
    compare_events();
  endtask

  task automatic idle_check(input int n);
    if (timed_out)
      return;
    repeat (n) @(posedge clk);
    compare_events();
  endtask

  // Random letter key, a few taps, then submit
  task automatic enter_letter(input int max_presses);
    int ia;
    int presses;
    ia      = $unsigned($random(seed)) % 8;
    presses = 1 + $unsigned($random(seed)) % max_presses;
    repeat (presses) press_key(letter_keys[ia]);
    press_key(KEY_SUBMIT_LETTER);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    held = '0;
    nRst = 1'b0;
    repeat (3) @(posedge clk);
    #1 nRst = 1'b1;
    model_reset();
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("Test %s: %0d errors", name, errors - start_errors);
  endtask

  initial begin
    int t_err;
    int ia;
    int ib;
    held = '0;
    nRst = 1'b0;
    model_reset();
    repeat (3) @(posedge clk);
    #1 nRst = 1'b1;

    t_err = errors;
    repeat (8) enter_letter(6);
    report_test("multi-tap runs", t_err);

    t_err = errors;
    repeat (4) begin
      ia = $unsigned($random(seed)) % 8;
      ib = (ia + 1 + $unsigned($random(seed)) % 7) % 8; // Always a different key
      repeat (1 + $unsigned($random(seed)) % 3) press_key(letter_keys[ia]);
      repeat (1 + $unsigned($random(seed)) % 6) press_key(letter_keys[ib]);
      press_key(KEY_SUBMIT_LETTER);
    end
    report_test("key change mid-run", t_err);

    t_err = errors;
    apply_reset();
    press_key(KEY_SUBMIT_LETTER); // Nothing pending after reset
    idle_check(50);
    ia = $unsigned($random(seed)) % 8;
    press_key(letter_keys[ia]);
    press_key(bad_keys[$unsigned($random(seed)) % 4]);
    press_key(letter_keys[ia]);
    press_key(bad_keys[$unsigned($random(seed)) % 4]);
    press_key(KEY_SUBMIT_LETTER);
    press_key(KEY_SUBMIT_LETTER); // Second submit has nothing left
    idle_check(50);
    report_test("invalid keys and empty submit", t_err);

    t_err = errors;
    ia = $unsigned($random(seed)) % 8;
    press_key(letter_keys[ia]);
    press_key(letter_keys[ia]);
    press_key(KEY_CLEAR);
    press_key(KEY_SUBMIT_LETTER);
    idle_check(50);
    enter_letter(3);
    report_test("clear", t_err);

    t_err = errors;
    press_key(KEY_SUBMIT_WORD); // Flush what earlier tests left
    repeat (WORD_LEN) enter_letter(3);
    press_key(KEY_SUBMIT_WORD);
    repeat (3) enter_letter(3);
    press_key(KEY_SUBMIT_WORD);   // Short word, no word_valid
    repeat (6) enter_letter(3);
    press_key(KEY_SUBMIT_WORD);   // Sixth letter dropped
    report_test("word assembly", t_err);

    t_err = errors;
    press_key(KEY_GAME_END);
    repeat (WORD_LEN) enter_letter(3);
    press_key(KEY_SUBMIT_WORD);
    enter_letter(3);
    press_key(KEY_SUBMIT_WORD);
    idle_check(20);
    report_test("game end", t_err);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/keypad_pkg.sv
rtl/letter_if.sv
rtl/keypad_scanner.sv
rtl/keypad_fsm.sv
rtl/word_assembler.sv
rtl/keypad_entry_top.sv
bench/keypad_entry_properties.sv
bench/keypad_entry_tb.sv

//--- Makefile
SIM      := verilator
TOP      := keypad_entry_tb
FILELIST := filelist.f
VFLAGS   := --binary --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Simulation PASSED'

clean:
	rm -rf $(OBJ_DIR)
